//--- logic/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // ======================================================================
    // Display geometry and bus pacing
    // ======================================================================
    localparam int TICK_DIV_DEFAULT = 125000;   // ~400 Hz from 50 MHz
    localparam int LINE_CHARS       = 16;
    localparam int SCREEN_CHARS     = 32;
    localparam int GLYPH_BYTES      = 64;       // 8 glyphs x 8 rows

    localparam int TIME_W  = 10;
    localparam int POINT_W = 7;

    localparam logic [7:0] ASCII_ZERO  = 8'h30;
    localparam logic [7:0] ASCII_SPACE = 8'h20;

    typedef logic [7:0] char_t;
    typedef logic [4:0] char_idx_t;
    typedef logic [5:0] glyph_addr_t;
    typedef logic [3:0] bcd_digit_t;

    // ======================================================================
    // HD44780 instruction bytes
    // ======================================================================
    typedef enum logic [7:0] {
        CMD_CLEAR        = 8'h01,
        CMD_ENTRY_MODE   = 8'h06,   // Auto-increment, no shift
        CMD_FUNCTION_SET = 8'h38,   // 8-bit bus, 2 lines, 5x8 font
        CMD_CGRAM_HOME   = 8'h40,
        CMD_LINE1_HOME   = 8'h80,
        CMD_LINE2_HOME   = 8'hC0
    } lcd_cmd_t;

    typedef enum logic [1:0] {
        GS_START  = 2'd0,
        GS_GAMING = 2'd1,
        GS_OVER   = 2'd2,
        GS_BLANK  = 2'd3            // All-space status line
    } game_state_t;

    typedef enum logic [3:0] {
        S_FUNC_SET = 4'd0,
        S_CLEAR    = 4'd1,
        S_ENTRY    = 4'd2,
        S_CG_HOME  = 4'd3,
        S_CG_WRITE = 4'd4,
        S_LINE1    = 4'd5,
        S_LINE2    = 4'd6,
        S_CHAR     = 4'd7,
        S_DROP_EN  = 4'd8,
        S_HOLD     = 4'd9
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/lcd_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_tick_gen #(
    parameter int tick_div = 125000
) (
    input  wire  Clk,
    input  wire  rst,
    output logic tick
);

    logic [31:0] count;

    always_ff @(posedge Clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == 32'(tick_div - 1)) begin
            count <= '0;
            tick  <= 1'b1;   // One Clk wide strobe
        end else begin
            count <= count + 32'd1;
            tick  <= 1'b0;
        end
    end

    // Strobe must stay a single cycle for any divider above one
    a_tick_single: assert property (@(posedge Clk) disable iff (!rst)
        (tick_div > 1 && tick) |=> !tick);

endmodule

`default_nettype wire

//--- logic/bin_to_bcd.sv
`timescale 1ns/1ns
`default_nettype none

module bin_to_bcd
    import lcd_pkg::*;
(
    input  wire  [13:0]          bin_value,
    output bcd_digit_t [3:0]     digits      // [3] thousands ... [0] ones
);

    logic [15:0] bcd;

    // Shift-and-add-3 over the input bits from the MSB down
    always_comb begin
        bcd = '0;
        for (int i = 13; i >= 0; i--) begin
            for (int d = 0; d < 4; d++) begin
                if (bcd[d*4 +: 4] > 4'd4)
                    bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
            end
            bcd = {bcd[14:0], bin_value[i]};
        end
    end

    assign digits = bcd;

endmodule

`default_nettype wire

//--- logic/status_text.sv
`timescale 1ns/1ns
`default_nettype none

module status_text
    import lcd_pkg::*;
(
    input  wire                Clk,
    input  wire                rst,
    input  game_state_t        game_state,
    input  wire [TIME_W-1:0]   time_value,
    input  wire [POINT_W-1:0]  point_value,
    input  char_idx_t          char_idx,
    output char_t              char_code
);

    bcd_digit_t [3:0] time_digits;
    bcd_digit_t [3:0] point_digits;

    logic [8*LINE_CHARS-1:0] line1_str;
    logic [8*LINE_CHARS-1:0] line2_str;

    char_t screen [SCREEN_CHARS];

    bin_to_bcd time_bcd (
        .bin_value (14'(time_value)),
        .digits    (time_digits)
    );

    bin_to_bcd point_bcd (
        .bin_value (14'(point_value)),
        .digits    (point_digits)
    );

    // ======================================================================
    // Line contents with the leftmost character in the top byte
    // ======================================================================
    always_comb begin
        case (game_state)
            GS_START:  line1_str = {{5{ASCII_SPACE}}, "START", {6{ASCII_SPACE}}};
            GS_GAMING: line1_str = {{5{ASCII_SPACE}}, "GAMING", {5{ASCII_SPACE}}};
            GS_OVER:   line1_str = {{3{ASCII_SPACE}}, "GAME OVER", {4{ASCII_SPACE}}};
            default:   line1_str = {LINE_CHARS{ASCII_SPACE}};
        endcase
    end

    // Points keep only tens and ones, so 100+ wraps
    assign line2_str = {"TIME:",
                        ASCII_ZERO + {4'h0, time_digits[2]},
                        ASCII_ZERO + {4'h0, time_digits[1]},
                        ASCII_ZERO + {4'h0, time_digits[0]},
                        "POINT:",
                        ASCII_ZERO + {4'h0, point_digits[1]},
                        ASCII_ZERO + {4'h0, point_digits[0]}};

    always_ff @(posedge Clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < SCREEN_CHARS; i++)
                screen[i] <= ASCII_SPACE;
        end else begin
            for (int i = 0; i < LINE_CHARS; i++) begin
                screen[i]              <= line1_str[8*(LINE_CHARS-1-i) +: 8];
                screen[LINE_CHARS + i] <= line2_str[8*(LINE_CHARS-1-i) +: 8];
            end
        end
    end

    assign char_code = screen[char_idx];

endmodule

`default_nettype wire

//--- logic/glyph_rom.sv
`timescale 1ns/1ns
`default_nettype none

module glyph_rom
    import lcd_pkg::*;
(
    input  glyph_addr_t glyph_addr,
    output char_t       glyph_byte
);

    // Glyph 0 is a plus-minus sign, the other seven are blank
    always_comb begin
        case (glyph_addr)
            6'd0:    glyph_byte = 8'h04;
            6'd1:    glyph_byte = 8'h04;
            6'd2:    glyph_byte = 8'h1F;   // Bar of the plus
            6'd3:    glyph_byte = 8'h04;
            6'd4:    glyph_byte = 8'h04;
            6'd5:    glyph_byte = 8'h00;
            6'd6:    glyph_byte = 8'h1F;   // Minus bar
            6'd7:    glyph_byte = 8'h00;   // Cursor row
            default: glyph_byte = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/lcd_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_sequencer
    import lcd_pkg::*;
(
    input  wire         Clk,
    input  wire         rst,
    input  wire         tick,
    input  char_t       char_code,
    output char_idx_t   char_idx,
    input  char_t       glyph_byte,
    output glyph_addr_t glyph_addr,
    output char_t       lcd_data,
    output logic        lcd_en,
    output logic        lcd_rs
);

    seq_state_t state;
    seq_state_t resume_state;    // Where to go after S_HOLD

    logic       byte_rs;
    char_t      byte_data;
    seq_state_t byte_next;

    logic last_glyph;
    logic en_at_tick;

    assign last_glyph = (glyph_addr == glyph_addr_t'(GLYPH_BYTES - 1));

    // ======================================================================
    // Byte to put on the bus from each issuing state
    // ======================================================================
    always_comb begin
        byte_rs   = 1'b0;
        byte_data = '0;
        byte_next = S_HOLD;
        case (state)
            S_FUNC_SET: begin
                byte_data = CMD_FUNCTION_SET;
                byte_next = S_CLEAR;
            end
            S_CLEAR: begin
                byte_data = CMD_CLEAR;
                byte_next = S_ENTRY;
            end
            S_ENTRY: begin
                byte_data = CMD_ENTRY_MODE;
                byte_next = S_CG_HOME;
            end
            S_CG_HOME: begin
                byte_data = CMD_CGRAM_HOME;
                byte_next = S_CG_WRITE;
            end
            S_CG_WRITE: begin
                byte_rs   = 1'b1;
                byte_data = glyph_byte;
                byte_next = last_glyph ? S_LINE1 : S_CG_WRITE;
            end
            S_LINE1: begin
                byte_data = CMD_LINE1_HOME;
                byte_next = S_CHAR;
            end
            S_LINE2: begin
                byte_data = CMD_LINE2_HOME;
                byte_next = S_CHAR;
            end
            S_CHAR: begin
                byte_rs   = 1'b1;
                byte_data = char_code;
                if (char_idx == char_idx_t'(LINE_CHARS - 1))
                    byte_next = S_LINE2;
                else if (char_idx == char_idx_t'(SCREEN_CHARS - 1))
                    byte_next = S_LINE1;
                else
                    byte_next = S_CHAR;
            end
            default: ;                 // Drop and hold issue nothing
        endcase
    end

    // ======================================================================
    // Each write cycle raises EN, drops EN, holds, then starts the next byte
    // ======================================================================
    always_ff @(posedge Clk or negedge rst) begin
        if (!rst) begin
            state        <= S_FUNC_SET;
            resume_state <= S_FUNC_SET;
            lcd_en       <= 1'b0;
            lcd_rs       <= 1'b0;
            lcd_data     <= '0;
            char_idx     <= '0;
            glyph_addr   <= '0;
            en_at_tick   <= 1'b0;
        end else if (tick) begin
            en_at_tick <= lcd_en;
            case (state)
                S_DROP_EN: begin
                    lcd_en <= 1'b0;    // Data stays on the bus
                    state  <= S_HOLD;
                end
                S_HOLD: state <= resume_state;
                default: begin
                    lcd_en       <= 1'b1;
                    lcd_rs       <= byte_rs;
                    lcd_data     <= byte_data;
                    resume_state <= byte_next;
                    state        <= S_DROP_EN;
                    if (state == S_CG_HOME)
                        glyph_addr <= '0;
                    if (state == S_CG_WRITE && !last_glyph)
                        glyph_addr <= glyph_addr + 1'b1;
                    if (state == S_CHAR)
                        char_idx <= char_idx + 1'b1;   // Wraps 31 -> 0
                end
            endcase
        end
    end

    a_en_one_tick: assert property (@(posedge Clk) disable iff (!rst)
        tick |-> !(lcd_en && en_at_tick));

    // CGRAM image is complete before the refresh loop and sent once only
    a_glyph_frozen: assert property (@(posedge Clk) disable iff (!rst)
        (state inside {S_LINE1, S_LINE2, S_CHAR}) |-> last_glyph && $stable(glyph_addr));

endmodule

`default_nettype wire

//--- logic/lcd_game_display.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_game_display
    import lcd_pkg::*;
#(
    parameter int tick_div = TICK_DIV_DEFAULT
) (
    input  wire                Clk,
    input  wire                rst,
    input  game_state_t        game_state,
    input  wire [TIME_W-1:0]   time_value,
    input  wire [POINT_W-1:0]  point_value,
    output char_t              lcd_data,
    output logic               lcd_en,
    output logic               lcd_rs,
    output logic               lcd_rw
);

    logic        tick;
    char_idx_t   char_idx;
    char_t       char_code;
    glyph_addr_t glyph_addr;
    char_t       glyph_byte;

    assign lcd_rw = 1'b0;   // LCD is never read

    lcd_tick_gen #(
        .tick_div (tick_div)
    ) tick_gen_inst (
        .Clk  (Clk),
        .rst  (rst),
        .tick (tick)
    );

    status_text status_text_inst (
        .Clk         (Clk),
        .rst         (rst),
        .game_state  (game_state),
        .time_value  (time_value),
        .point_value (point_value),
        .char_idx    (char_idx),
        .char_code   (char_code)
    );

    glyph_rom glyph_rom_inst (
        .glyph_addr (glyph_addr),
        .glyph_byte (glyph_byte)
    );

    lcd_sequencer sequencer_inst (
        .Clk        (Clk),
        .rst        (rst),
        .tick       (tick),
        .char_code  (char_code),
        .char_idx   (char_idx),
        .glyph_byte (glyph_byte),
        .glyph_addr (glyph_addr),
        .lcd_data   (lcd_data),
        .lcd_en     (lcd_en),
        .lcd_rs     (lcd_rs)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic Clk,
    output logic rst
);

    // 10 ns period
    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Active low for the first two rising edges
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge Clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_lcd_game_display.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lcd_game_display
    import lcd_pkg::*;
();

    localparam int WAIT_LIMIT = 64;    // Longer than one byte slot in Clk cycles

    logic                Clk;
    logic                rst;
    game_state_t         game_state;
    logic [TIME_W-1:0]   time_value;
    logic [POINT_W-1:0]  point_value;
    char_t               lcd_data;
    logic                lcd_en;
    logic                lcd_rs;
    logic                lcd_rw;

    int    errors   = 0;
    int    checks   = 0;
    int    timeouts = 0;
    logic  cap_rs;
    char_t cap_data;
    int    cap_width;

    tb_clock clock_inst (
        .Clk (Clk),
        .rst (rst)
    );

    lcd_game_display #(
        .tick_div (4)
    ) lcd_game_display_inst (
        .Clk         (Clk),
        .rst         (rst),
        .game_state  (game_state),
        .time_value  (time_value),
        .point_value (point_value),
        .lcd_data    (lcd_data),
        .lcd_en      (lcd_en),
        .lcd_rs      (lcd_rs),
        .lcd_rw      (lcd_rw)
    );

    // ======================================================================
    // Compare tasks and expected screen contents
    // ======================================================================
    task automatic check_byte(input char_t expected, input char_t actual, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_rs(input logic expected, input logic actual, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_cmd(input lcd_cmd_t expected, input lcd_cmd_t actual, input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected command 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_width(input int expected, input int actual, input string name);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %0d cycles, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    function automatic char_t line1_char(input game_state_t gs, input int idx);
        string s;
        case (gs)
            GS_START:  s = "     START      ";
            GS_GAMING: s = "     GAMING     ";
            GS_OVER:   s = "   GAME OVER    ";
            default:   s = "                ";
        endcase
        return char_t'(s[idx]);
    endfunction

    // Time keeps three digits and points keep two
    function automatic char_t line2_char(input int idx, input int tv, input int pv);
        string s;
        s = $sformatf("TIME:%03dPOINT:%02d", tv % 1000, pv % 100);
        return char_t'(s[idx]);
    endfunction

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // A wait that gave up ends the run on the next rising edge
    always @(posedge Clk) begin
        if (timeouts != 0) begin
            finish_run();
        end
    end

    // ======================================================================
    // Bus capture on the falling Clk edge
    // ======================================================================
    task automatic capture_byte();
        int waited;
        bit seen_high;
        bit done;
        waited    = 0;
        seen_high = 1'b0;
        done      = 1'b0;
        cap_width = 0;
        while (!done && waited < WAIT_LIMIT) begin
            if (lcd_en === 1'b1) begin
                seen_high = 1'b1;
                cap_width++;
            end else if (seen_high) begin
                cap_rs   = lcd_rs;        // Data still held after EN falls
                cap_data = lcd_data;
                done     = 1'b1;
            end
            if (!done) begin
                @(negedge Clk);
                waited++;
            end
        end
        if (!done) begin
            $display("Timeout at %0t ns: no falling edge of lcd_en seen", $time);
            timeouts++;
            @(negedge Clk);   // Run ends at the rising edge before this one
        end
    endtask

    task automatic apply_inputs(input game_state_t gs, input int tv, input int pv);
        @(posedge Clk);
        game_state  <= gs;
        time_value  <= TIME_W'(tv);
        point_value <= POINT_W'(pv);
        @(negedge Clk);
    endtask

    // One full refresh frame with inputs changed just after the line 1 command
    task automatic check_frame(input game_state_t gs, input int tv, input int pv);
        capture_byte();
        check_cmd(CMD_LINE1_HOME, lcd_cmd_t'(cap_data), "lcd_data");
        check_rs(1'b0, cap_rs, "lcd_rs");
        apply_inputs(gs, tv, pv);
        for (int i = 0; i < LINE_CHARS; i++) begin
            capture_byte();
            check_rs(1'b1, cap_rs, "lcd_rs");
            check_byte(line1_char(gs, i), cap_data, "lcd_data");
        end
        capture_byte();
        check_cmd(CMD_LINE2_HOME, lcd_cmd_t'(cap_data), "lcd_data");
        check_rs(1'b0, cap_rs, "lcd_rs");
        for (int i = 0; i < LINE_CHARS; i++) begin
            capture_byte();
            check_rs(1'b1, cap_rs, "lcd_rs");
            check_byte(line2_char(i, tv, pv), cap_data, "lcd_data");
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset();
        int waited;
        waited = 0;
        @(negedge Clk);
        while (lcd_en !== 1'b1 && waited < WAIT_LIMIT) begin
            check_rs(1'b0, lcd_rs, "lcd_rs");
            check_rs(1'b0, lcd_rw, "lcd_rw");
            check_byte(8'h00, lcd_data, "lcd_data");
            @(negedge Clk);
            waited++;
        end
        if (lcd_en !== 1'b1) begin
            $display("Timeout at %0t ns: lcd_en never rose after reset", $time);
            timeouts++;
            @(negedge Clk);   // Run ends at the rising edge before this one
        end
    endtask

    task automatic test_setup_sequence();
        lcd_cmd_t expected [4];
        expected = '{CMD_FUNCTION_SET, CMD_CLEAR, CMD_ENTRY_MODE, CMD_CGRAM_HOME};
        for (int i = 0; i < 4; i++) begin
            capture_byte();
            check_cmd(expected[i], lcd_cmd_t'(cap_data), "lcd_data");
            check_rs(1'b0, cap_rs, "lcd_rs");
            check_width(4, cap_width, "lcd_en high time");
        end
    endtask

    task automatic test_glyph_load();
        char_t rows [8];
        rows = '{8'h04, 8'h04, 8'h1F, 8'h04, 8'h04, 8'h00, 8'h1F, 8'h00};
        for (int i = 0; i < GLYPH_BYTES; i++) begin
            capture_byte();
            check_rs(1'b1, cap_rs, "lcd_rs");
            check_byte((i < 8) ? rows[i] : 8'h00, cap_data, "lcd_data");
        end
    endtask

    task automatic test_status_line();
        check_frame(GS_START, 0, 0);
        check_frame(GS_GAMING, 0, 0);
        check_frame(GS_OVER, 0, 0);
        check_frame(GS_BLANK, 0, 0);
    endtask

    task automatic test_numbers_line();
        check_frame(GS_GAMING, 0, 0);
        check_frame(GS_GAMING, 999, 127);  // Points wrap to 27
        check_frame(GS_OVER, 1023, 99);    // Time wraps to 023
        for (int n = 0; n < 4; n++) begin
            check_frame(GS_GAMING, int'($urandom % 1024), int'($urandom % 128));
        end
    endtask

    // Byte after character 31 must be the line 1 command, never a glyph
    task automatic test_frame_repeat();
        capture_byte();
        check_cmd(CMD_LINE1_HOME, lcd_cmd_t'(cap_data), "lcd_data");
        check_rs(1'b0, cap_rs, "lcd_rs");
        check_width(4, cap_width, "lcd_en high time");
    endtask

    initial begin
        void'($urandom(41414));
        game_state  = GS_START;
        time_value  = '0;
        point_value = '0;
        test_reset();
        test_setup_sequence();
        test_glyph_load();
        test_status_line();
        test_numbers_line();
        test_frame_repeat();
        finish_run();
    end

endmodule

`default_nettype wire

//--- flist.f
logic/lcd_pkg.sv
logic/lcd_tick_gen.sv
logic/bin_to_bcd.sv
logic/status_text.sv
logic/glyph_rom.sv
logic/lcd_sequencer.sv
logic/lcd_game_display.sv
testbench/tb_clock.sv
testbench/tb_lcd_game_display.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_lcd_game_display
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
